/* requant.f */
common/requant_pkg.sv
hw/quant_param_regs.sv
vecop/acc_scale_vecop.sv
vecop/product_add_bias_vecop.sv
vecop/shift_clip_vecop.sv
hw/requant_core.sv
sim/requant_assertions.sv
sim/requant_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module requant_tb -f requant.f -o requant_sim
	./obj_dir/requant_sim 2>&1 | tee sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/requant_tb.sv */
`default_nettype none

module requant_tb;

  logic                                                    clk = 1'b0;
  logic                                                    reset;
  logic                                                    param_wr;
  logic                                                    param_ch;
  logic [requant_pkg::scale_width-1:0]                     param_scale;
  logic [requant_pkg::bias_width-1:0]                      param_bias;
  logic [requant_pkg::shift_width-1:0]                     param_shift;
  logic                                                    param_relu;
  logic                                                    acc_valid;
  logic                                                    acc_mode;
  logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] acc_vec;
  logic                                                    out_valid;
  logic                                                    out_mode;
  requant_pkg::out_vec_u                                   out_vec;

  // model copy of the parameter registers
  logic [requant_pkg::scale_width-1:0] m_scale [2];
  logic [requant_pkg::bias_width-1:0]  m_bias  [2];
  logic [requant_pkg::shift_width-1:0] m_shift [2];
  logic                                m_relu  [2];

  logic [requant_pkg::out_vec_width-1:0] exp_word_q [$];
  logic                                  exp_mode_q [$];
  logic [requant_pkg::out_vec_width-1:0] last_vec;
  logic                                  reset_q;

  requant_core requant_core_inst (
    .clk        (clk),
    .reset      (reset),
    .param_wr   (param_wr),
    .param_ch   (param_ch),
    .param_scale(param_scale),
    .param_bias (param_bias),
    .param_shift(param_shift),
    .param_relu (param_relu),
    .acc_valid  (acc_valid),
    .acc_mode   (acc_mode),
    .acc_vec    (acc_vec),
    .out_valid  (out_valid),
    .out_mode   (out_mode),
    .out_vec    (out_vec)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic void clear_model();
    for (int c = 0; c < 2; c++) begin
      m_scale[c] = '0;
      m_bias[c]  = '0;
      m_shift[c] = '0;
      m_relu[c]  = 1'b0;
    end
  endfunction

  // scale, bias, rounding shift, relu, saturation per lane
  function automatic logic [requant_pkg::out_vec_width-1:0] expected_word(
    input logic mode,
    input logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] vec
  );
    logic [requant_pkg::out_vec_width-1:0] w;
    longint v;
    longint hi;
    longint lo;
    int ch;
    int lanes;
    int ow;
    w = '0;
    lanes = mode ? requant_pkg::lane_num : requant_pkg::lanes_per_ch;
    ow = mode ? requant_pkg::out8_width : requant_pkg::out16_width;
    hi = (longint'(1) << (ow - 1)) - 1;
    lo = -hi - 1;
    for (int i = 0; i < lanes; i++) begin
      ch = (i >= requant_pkg::lanes_per_ch) ? 1 : 0;  // mode 0 never gets here
      v = $signed(vec[i*requant_pkg::acc_width +: requant_pkg::acc_width]);
      v = v * longint'(m_scale[ch]) + longint'($signed(m_bias[ch]));
      if (m_shift[ch] != 0)
        v = v + (longint'(1) << (m_shift[ch] - 1));
      v = v >>> m_shift[ch];
      if (m_relu[ch] && v < 0)
        v = 0;
      if (v > hi)
        v = hi;
      else if (v < lo)
        v = lo;
      if (mode)
        w[i*requant_pkg::out8_width +: requant_pkg::out8_width] = v[7:0];
      else
        w[i*requant_pkg::out16_width +: requant_pkg::out16_width] = v[15:0];
    end
    return w;
  endfunction

  // signed lanes below 2^(mag_bits-1) in magnitude
  function automatic logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] rand_vec(
    input int mag_bits
  );
    logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] v;
    int x;
    for (int i = 0; i < requant_pkg::lane_num; i++) begin
      x = $urandom;
      x = x >>> (32 - mag_bits);
      v[i*requant_pkg::acc_width +: requant_pkg::acc_width] = x;
    end
    return v;
  endfunction

  task automatic write_param(input int ch, input logic [7:0] scale, input logic [7:0] bias,
                             input logic [4:0] shift, input logic relu);
    @(negedge clk);
    acc_valid   = 1'b0;
    param_wr    = 1'b1;
    param_ch    = ch[0];
    param_scale = scale;
    param_bias  = bias;
    param_shift = shift;
    param_relu  = relu;
    m_scale[ch] = scale;
    m_bias[ch]  = bias;
    m_shift[ch] = shift;
    m_relu[ch]  = relu;
    @(negedge clk);
    param_wr = 1'b0;
  endtask

  task automatic send_beat(input logic mode,
                           input logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] vec);
    @(negedge clk);
    acc_valid = 1'b1;
    acc_mode  = mode;
    acc_vec   = vec;
    exp_word_q.push_back(expected_word(mode, vec));
    exp_mode_q.push_back(mode);
  endtask

  // junk on the data inputs while idle, outputs must hold
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      acc_valid = 1'b0;
      acc_mode  = 1'($urandom);
      acc_vec   = rand_vec(32);
    end
  endtask

  task automatic drain();
    int n;
    idle(1);
    n = 0;
    while (exp_word_q.size() != 0) begin
      assert (n < 10) else fail_stop("timeout waiting for outstanding beats to come out");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    acc_valid = 1'b0;
    reset     = 1'b1;
    repeat (2) @(negedge clk);
    exp_word_q.delete();  // beats in flight are lost
    exp_mode_q.delete();
    clear_model();
    reset = 1'b0;
  endtask

  always @(posedge clk)
    reset_q <= reset;

  always @(negedge clk) begin : check_out
    logic [requant_pkg::out_vec_width-1:0] exp_word;
    logic                                  exp_mode;
    if (reset_q) begin
      assert (out_valid == 1'b0 && out_vec == '0)
        else fail_stop($sformatf("outputs not cleared by reset at %0t", $time));
      last_vec = '0;
    end else if (out_valid) begin
      assert (exp_word_q.size() != 0)
        else fail_stop($sformatf("out_valid at %0t with no beat outstanding", $time));
      exp_word = exp_word_q.pop_front();
      exp_mode = exp_mode_q.pop_front();
      assert (out_mode == exp_mode)
        else fail_stop($sformatf("Mismatch at %0t: out_mode expected %0b got %0b",
                                 $time, exp_mode, out_mode));
      assert (out_vec == exp_word)
        else fail_stop($sformatf("Mismatch at %0t: out_vec expected %h got %h",
                                 $time, exp_word, out_vec));
      last_vec = exp_word;
    end else begin
      assert (out_vec == last_vec)
        else fail_stop($sformatf("Mismatch at %0t: out_vec (hold) expected %h got %h",
                                 $time, last_vec, out_vec));
    end
  end

  initial begin
    void'($urandom(32'he313));
    reset       = 1'b1;
    param_wr    = 1'b0;
    param_ch    = 1'b0;
    param_scale = '0;
    param_bias  = '0;
    param_shift = '0;
    param_relu  = 1'b0;
    acc_valid   = 1'b0;
    acc_mode    = 1'b0;
    acc_vec     = '0;
    clear_model();
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // mode 0, one channel, 16 bit results
    write_param(0, 8'($urandom), 8'($urandom), 5'($urandom_range(4, 12)), 1'b0);
    repeat (8) send_beat(1'b0, rand_vec(14));
    drain();

    // mode 1, channels differ
    write_param(0, 8'($urandom), 8'($urandom), 5'($urandom_range(6, 14)), 1'b0);
    write_param(1, 8'($urandom), 8'($urandom), 5'($urandom_range(6, 14)), 1'b0);
    repeat (8) send_beat(1'b1, rand_vec(14));
    drain();

    // saturation at both shift extremes, relu on and off
    for (int s = 0; s < 2; s++) begin
      for (int r = 0; r < 2; r++) begin
        write_param(0, 8'hff, 8'($urandom), s ? 5'd31 : 5'd0, r[0]);
        write_param(1, 8'h80, 8'($urandom), s ? 5'd31 : 5'd0, !r[0]);
        repeat (3) send_beat(1'b0, rand_vec(32));
        repeat (3) send_beat(1'b1, rand_vec(32));
        send_beat(1'b0, {32{32'h80000000, 32'h7fffffff}});
        send_beat(1'b1, {32{32'h80000000, 32'h7fffffff}});
        drain();
      end
    end

    // back to back, alternating mode
    write_param(0, 8'($urandom), 8'($urandom), 5'($urandom_range(8, 16)), 1'b1);
    write_param(1, 8'($urandom), 8'($urandom), 5'($urandom_range(8, 16)), 1'b0);
    for (int k = 0; k < 12; k++)
      send_beat(k[0], rand_vec(20));
    drain();

    // random gaps
    repeat (20) begin
      send_beat(1'($urandom), rand_vec(20));
      idle($urandom_range(0, 3));
    end
    drain();

    // reset with beats in flight, parameters back to zero
    repeat (3) send_beat(1'($urandom), rand_vec(20));
    apply_reset();
    repeat (4) send_beat(1'($urandom), rand_vec(32));
    drain();
    write_param(0, 8'($urandom), 8'($urandom), 5'($urandom_range(4, 12)), 1'b0);
    write_param(1, 8'($urandom), 8'($urandom), 5'($urandom_range(4, 12)), 1'b1);
    repeat (4) send_beat(1'($urandom), rand_vec(16));
    drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/requant_assertions.sv */
`default_nettype none

module requant_assertions (
  input logic clk,
  input logic reset,
  input logic acc_valid,
  input logic acc_mode,
  input logic out_valid,
  input logic out_mode
);

  logic armed = 1'b0;  // first edge has no history yet

  always @(posedge clk)
    armed <= 1'b1;

  property p_quiet_after_reset;
    @(posedge clk) (armed && ($past(reset, 1) || $past(reset, 2))) |-> !out_valid;
  endproperty

  // three register stages, no stall
  property p_valid_latency;
    @(posedge clk) disable iff (reset)
      (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
        |-> (out_valid == $past(acc_valid, 3));
  endproperty

  property p_mode_latency;
    @(posedge clk) disable iff (reset)
      out_valid |-> (out_mode == $past(acc_mode, 3));
  endproperty

  a_quiet_after_reset: assert property (p_quiet_after_reset)
    else $error("out_valid high during reset or in the cycle after it");
  a_valid_latency: assert property (p_valid_latency)
    else $error("out_valid does not follow acc_valid by three cycles");
  a_mode_latency: assert property (p_mode_latency)
    else $error("out_mode does not match the mode of its beat");

endmodule

bind requant_core requant_assertions requant_assertions_inst (
  .clk      (clk),
  .reset    (reset),
  .acc_valid(acc_valid),
  .acc_mode (acc_mode),
  .out_valid(out_valid),
  .out_mode (out_mode)
);

`default_nettype wire

/* hw/requant_core.sv */
`default_nettype none

module requant_core (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   param_wr,
  input  logic                                                   param_ch,
  input  logic [requant_pkg::scale_width-1:0]                    param_scale,
  input  logic [requant_pkg::bias_width-1:0]                     param_bias,
  input  logic [requant_pkg::shift_width-1:0]                    param_shift,
  input  logic                                                   param_relu,
  input  logic                                                   acc_valid,
  input  logic                                                   acc_mode,
  input  logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0] acc_vec,
  output logic                                                   out_valid,
  output logic                                                   out_mode,
  output requant_pkg::out_vec_u                                  out_vec
);

  logic [requant_pkg::scale_width-1:0] scale_ch0, scale_ch1;
  logic [requant_pkg::bias_width-1:0]  bias_ch0, bias_ch1;
  logic [requant_pkg::shift_width-1:0] shift_ch0, shift_ch1;
  logic                                relu_ch0, relu_ch1;

  // stage 1 -> 2 -> 3
  logic                                                    s1_valid, s1_mode;
  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] prod_vec;
  logic                                                    s2_valid, s2_mode;
  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] biased_vec;

  quant_param_regs quant_param_regs_inst (
    .clk        (clk),
    .reset      (reset),
    .param_wr   (param_wr),
    .param_ch   (param_ch),
    .param_scale(param_scale),
    .param_bias (param_bias),
    .param_shift(param_shift),
    .param_relu (param_relu),
    .scale_ch0  (scale_ch0),
    .scale_ch1  (scale_ch1),
    .bias_ch0   (bias_ch0),
    .bias_ch1   (bias_ch1),
    .shift_ch0  (shift_ch0),
    .shift_ch1  (shift_ch1),
    .relu_ch0   (relu_ch0),
    .relu_ch1   (relu_ch1)
  );

  acc_scale_vecop acc_scale_vecop_inst (
    .clk      (clk),
    .reset    (reset),
    .valid_in (acc_valid),
    .mode_in  (acc_mode),
    .acc_vec  (acc_vec),
    .scale_ch0(scale_ch0),
    .scale_ch1(scale_ch1),
    .valid_out(s1_valid),
    .mode_out (s1_mode),
    .prod_vec (prod_vec)
  );

  product_add_bias_vecop product_add_bias_vecop_inst (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (s1_valid),
    .mode_in   (s1_mode),
    .prod_vec  (prod_vec),
    .bias_ch0  (bias_ch0),
    .bias_ch1  (bias_ch1),
    .valid_out (s2_valid),
    .mode_out  (s2_mode),
    .biased_vec(biased_vec)
  );

  shift_clip_vecop shift_clip_vecop_inst (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (s2_valid),
    .mode_in   (s2_mode),
    .biased_vec(biased_vec),
    .shift_ch0 (shift_ch0),
    .shift_ch1 (shift_ch1),
    .relu_ch0  (relu_ch0),
    .relu_ch1  (relu_ch1),
    .valid_out (out_valid),
    .mode_out  (out_mode),
    .out_vec   (out_vec)
  );

endmodule

`default_nettype wire

/* vecop/shift_clip_vecop.sv */
`default_nettype none

module shift_clip_vecop (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    valid_in,
  input  logic                                                    mode_in,
  input  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] biased_vec,
  input  logic [requant_pkg::shift_width-1:0]                     shift_ch0,
  input  logic [requant_pkg::shift_width-1:0]                     shift_ch1,
  input  logic                                                    relu_ch0,
  input  logic                                                    relu_ch1,
  output logic                                                    valid_out,
  output logic                                                    mode_out,
  output requant_pkg::out_vec_u                                   out_vec
);

  localparam logic signed [requant_pkg::prod_width-1:0] rnd_one = 1;
  localparam logic signed [requant_pkg::prod_width-1:0] max16 =
      2 ** (requant_pkg::out16_width - 1) - 1;
  localparam logic signed [requant_pkg::prod_width-1:0] min16 =
      -(2 ** (requant_pkg::out16_width - 1));
  localparam logic signed [requant_pkg::prod_width-1:0] max8 =
      2 ** (requant_pkg::out8_width - 1) - 1;
  localparam logic signed [requant_pkg::prod_width-1:0] min8 =
      -(2 ** (requant_pkg::out8_width - 1));

  logic [requant_pkg::out16_width-1:0] sat16 [requant_pkg::lanes_per_ch];
  logic [requant_pkg::out8_width-1:0]  sat8  [requant_pkg::lane_num];
  requant_pkg::out_vec_u               out_next;

  genvar i;
  for (i = 0; i < requant_pkg::lane_num; i++) begin : g_lane
    logic        [requant_pkg::shift_width-1:0] shift;
    logic                                       relu;
    logic signed [requant_pkg::prod_width-1:0]  val, rnd, shifted, clipped;
    logic signed [requant_pkg::prod_width-1:0]  clamp8;

    assign shift = (i < requant_pkg::lanes_per_ch) ? shift_ch0 : shift_ch1;
    assign relu  = (i < requant_pkg::lanes_per_ch) ? relu_ch0 : relu_ch1;
    assign val   = $signed(biased_vec[i*requant_pkg::prod_width +: requant_pkg::prod_width]);

    // round half up, no headroom issue since |E*acc| < 2^39 - 2^30
    assign rnd     = (shift == '0) ? '0 : (rnd_one << (shift - 1'b1));
    assign shifted = (val + rnd) >>> shift;
    assign clipped = (relu && shifted < 0) ? '0 : shifted;

    assign clamp8  = (clipped > max8) ? max8 : (clipped < min8) ? min8 : clipped;
    assign sat8[i] = clamp8[requant_pkg::out8_width-1:0];

    if (i < requant_pkg::lanes_per_ch) begin : g_px16
      logic signed [requant_pkg::prod_width-1:0] clamp16;

      assign clamp16  = (clipped > max16) ? max16 : (clipped < min16) ? min16 : clipped;
      assign sat16[i] = clamp16[requant_pkg::out16_width-1:0];
    end
  end

  // pack the word through the view that matches the beat's mode
  always_comb begin
    out_next = '0;
    if (mode_in) begin
      for (int k = 0; k < requant_pkg::lane_num; k++) begin
        out_next.px8[k] = sat8[k];
      end
    end else begin
      for (int k = 0; k < requant_pkg::lanes_per_ch; k++) begin
        out_next.px16[k] = sat16[k];  // upper half left zero
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      mode_out  <= 1'b0;
      out_vec   <= '0;
    end else begin
      valid_out <= valid_in;
      if (valid_in) begin
        mode_out <= mode_in;
        out_vec  <= out_next;
      end
    end
  end

endmodule

`default_nettype wire

/* vecop/product_add_bias_vecop.sv */
`default_nettype none

module product_add_bias_vecop (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    valid_in,
  input  logic                                                    mode_in,
  input  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] prod_vec,
  input  logic [requant_pkg::bias_width-1:0]                      bias_ch0,
  input  logic [requant_pkg::bias_width-1:0]                      bias_ch1,
  output logic                                                    valid_out,
  output logic                                                    mode_out,
  output logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] biased_vec
);

  localparam int ext_width = requant_pkg::prod_width - requant_pkg::bias_width;

  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] biased_next;

  genvar i;
  for (i = 0; i < requant_pkg::lane_num; i++) begin : g_lane
    logic [requant_pkg::bias_width-1:0] bias;
    logic [requant_pkg::prod_width-1:0] bias_ext;
    logic [requant_pkg::prod_width-1:0] sum;  // wraps at 40 bits

    assign bias     = (i < requant_pkg::lanes_per_ch) ? bias_ch0 : bias_ch1;
    assign bias_ext = {{ext_width{bias[requant_pkg::bias_width-1]}}, bias};
    assign sum = prod_vec[i*requant_pkg::prod_width +: requant_pkg::prod_width] + bias_ext;

    // high lanes stay zero in mode 0, bias would leak in otherwise
    assign biased_next[i*requant_pkg::prod_width +: requant_pkg::prod_width] =
        ((i < requant_pkg::lanes_per_ch) || mode_in) ? sum : '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out  <= 1'b0;
      mode_out   <= 1'b0;
      biased_vec <= '0;
    end else begin
      valid_out <= valid_in;
      if (valid_in) begin
        mode_out   <= mode_in;
        biased_vec <= biased_next;
      end
    end
  end

endmodule

`default_nettype wire

/* vecop/acc_scale_vecop.sv */
`default_nettype none

module acc_scale_vecop (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    valid_in,
  input  logic                                                    mode_in,
  input  logic [requant_pkg::lane_num*requant_pkg::acc_width-1:0]  acc_vec,
  input  logic [requant_pkg::scale_width-1:0]                     scale_ch0,
  input  logic [requant_pkg::scale_width-1:0]                     scale_ch1,
  output logic                                                    valid_out,
  output logic                                                    mode_out,
  output logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] prod_vec
);

  logic [requant_pkg::lane_num*requant_pkg::prod_width-1:0] prod_next;

  genvar i;
  for (i = 0; i < requant_pkg::lane_num; i++) begin : g_lane
    logic signed [requant_pkg::acc_width-1:0]  acc;
    logic        [requant_pkg::scale_width-1:0] scale;
    logic signed [requant_pkg::prod_width-1:0] prod;
    logic                                      lane_on;

    assign acc = $signed(acc_vec[i*requant_pkg::acc_width +: requant_pkg::acc_width]);
    // low half is channel 0 in both modes
    assign scale   = (i < requant_pkg::lanes_per_ch) ? scale_ch0 : scale_ch1;
    assign lane_on = (i < requant_pkg::lanes_per_ch) || mode_in;

    // zero-extend E so it multiplies as a positive value
    assign prod = acc * $signed({1'b0, scale});

    assign prod_next[i*requant_pkg::prod_width +: requant_pkg::prod_width] =
        lane_on ? prod : '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      mode_out  <= 1'b0;
      prod_vec  <= '0;
    end else begin
      valid_out <= valid_in;
      if (valid_in) begin
        mode_out <= mode_in;
        prod_vec <= prod_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/quant_param_regs.sv */
`default_nettype none

module quant_param_regs (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 param_wr,
  input  logic                                 param_ch,
  input  logic [requant_pkg::scale_width-1:0]  param_scale,
  input  logic [requant_pkg::bias_width-1:0]   param_bias,
  input  logic [requant_pkg::shift_width-1:0]  param_shift,
  input  logic                                 param_relu,
  output logic [requant_pkg::scale_width-1:0]  scale_ch0,
  output logic [requant_pkg::scale_width-1:0]  scale_ch1,
  output logic [requant_pkg::bias_width-1:0]   bias_ch0,
  output logic [requant_pkg::bias_width-1:0]   bias_ch1,
  output logic [requant_pkg::shift_width-1:0]  shift_ch0,
  output logic [requant_pkg::shift_width-1:0]  shift_ch1,
  output logic                                 relu_ch0,
  output logic                                 relu_ch1
);

  // both sets go out as is, stages pick per lane
  always_ff @(posedge clk) begin
    if (reset) begin
      scale_ch0 <= '0;
      scale_ch1 <= '0;
      bias_ch0  <= '0;
      bias_ch1  <= '0;
      shift_ch0 <= '0;
      shift_ch1 <= '0;
      relu_ch0  <= 1'b0;
      relu_ch1  <= 1'b0;
    end else if (param_wr) begin
      if (param_ch) begin
        scale_ch1 <= param_scale;
        bias_ch1  <= param_bias;
        shift_ch1 <= param_shift;
        relu_ch1  <= param_relu;
      end else begin
        scale_ch0 <= param_scale;
        bias_ch0  <= param_bias;
        shift_ch0 <= param_shift;
        relu_ch0  <= param_relu;
      end
    end
  end

endmodule

`default_nettype wire

/* common/requant_pkg.sv */
`default_nettype none

package requant_pkg;

  // array geometry
  localparam int column_num = 16;
  localparam int pixel_par = 2;
  localparam int lanes_per_ch = column_num * pixel_par;
  localparam int lane_num = 2 * lanes_per_ch;  // mode 1, two channels

  // datapath widths
  localparam int acc_width = 32;
  localparam int scale_width = 8;  // unsigned E
  localparam int prod_width = acc_width + scale_width;
  localparam int bias_width = 8;
  localparam int shift_width = 5;

  localparam int out8_width = 8;
  localparam int out16_width = 16;
  localparam int out_vec_width = lane_num * out8_width;

  // one output word, read as 32 x 16 bit (mode 0) or 64 x 8 bit (mode 1)
  typedef union packed {
    logic [out_vec_width/out16_width-1:0][out16_width-1:0] px16;
    logic [out_vec_width/out8_width-1:0][out8_width-1:0]   px8;
  } out_vec_u;

endpackage

`default_nettype wire
